/* src/mem_pkg.sv */
// Word, address and strobe types, address decode bits and arbiter states.
package mem_pkg;

    // ##########################################################################
    // Bus types.
    // ##########################################################################

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [16:0] waddr_t;   // Byte address bits 18:2.
    typedef logic [3:0]  strb_t;    // Nonzero means write.

    // ##########################################################################
    // Address decode.
    // ##########################################################################

    localparam int MEM_SEL_BIT   = 30;  // External memory.
    localparam int TIMER_SEL_BIT = 28;  // Timer when bit 30 is clear.
    localparam int WADDR_MSB     = 18;
    localparam int WADDR_LSB     = 2;

    // Arbiter grant.
    typedef enum logic [1:0] {
        IDLE,
        DATA,
        FETCH
    } grant_e;

endpackage

/* src/mem_req_if.sv */
// Valid/ready memory request channel with requester and responder modports.
`timescale 1ns/1ns

interface mem_req_if;
    import mem_pkg::*;

    logic   valid;
    logic   ready;
    strb_t  wstrb;  // Zero for reads.
    waddr_t addr;
    word_t  wdata;
    word_t  rdata;  // Sampled in the ready cycle.

    modport requester (
        output valid, wstrb, addr, wdata,
        input  ready, rdata
    );

    modport responder (
        input  valid, wstrb, addr, wdata,
        output ready, rdata
    );

endinterface

/* src/bus_decoder.sv */
// Core data bus decoder routing accesses to external memory or the timer.
`timescale 1ns/1ns

module bus_decoder (
    input  logic           data_sel_i,
    input  mem_pkg::addr_t data_addr_i,
    input  mem_pkg::word_t data_wdata_i,
    input  mem_pkg::strb_t data_mask_i,
    output mem_pkg::word_t data_rdata_o,
    output logic           data_stall_o,

    mem_req_if.requester   mem_ch,
    mem_req_if.requester   timer_ch
);
    import mem_pkg::*;

    logic   mem_hit;
    logic   timer_hit;
    waddr_t word_addr;

    // Memory wins over the timer.
    assign mem_hit   = data_addr_i[MEM_SEL_BIT];
    assign timer_hit = !data_addr_i[MEM_SEL_BIT] && data_addr_i[TIMER_SEL_BIT];
    assign word_addr = data_addr_i[WADDR_MSB:WADDR_LSB];

    assign mem_ch.valid = data_sel_i && mem_hit;
    assign mem_ch.wstrb = data_mask_i;
    assign mem_ch.addr  = word_addr;
    assign mem_ch.wdata = data_wdata_i;

    assign timer_ch.valid = data_sel_i && timer_hit;
    assign timer_ch.wstrb = data_mask_i;
    assign timer_ch.addr  = word_addr;
    assign timer_ch.wdata = data_wdata_i;

    // Read data and stall from the selected channel.
    always_comb begin
        if (mem_hit) begin
            data_rdata_o = mem_ch.rdata;
            data_stall_o = data_sel_i && !mem_ch.ready;
        end else if (timer_hit) begin
            data_rdata_o = timer_ch.rdata;
            data_stall_o = data_sel_i && !timer_ch.ready;
        end else begin
            data_rdata_o = '0;      // Unmapped.
            data_stall_o = 1'b0;
        end
    end

endmodule

/* src/fetch_buffer.sv */
// One-word instruction fetch buffer that reads memory on a miss.
`timescale 1ns/1ns

module fetch_buffer (
    input  logic            clk_i,
    input  logic            rst_n_i,

    input  mem_pkg::waddr_t fetch_addr_i,
    output mem_pkg::word_t  fetch_word_o,
    output logic            fetch_wait_o,

    mem_req_if.requester    mem_ch
);
    import mem_pkg::*;

    waddr_t tag_q;
    word_t  word_q;
    logic   valid_q;
    logic   hit;
    logic   fill;

    assign hit  = valid_q && (tag_q == fetch_addr_i);
    assign fill = mem_ch.valid && mem_ch.ready;

    assign fetch_word_o = word_q;
    assign fetch_wait_o = !hit;

    // Read request held until the fill; the core keeps the address stable.
    assign mem_ch.valid = !hit;
    assign mem_ch.wstrb = '0;
    assign mem_ch.addr  = fetch_addr_i;
    assign mem_ch.wdata = '0;

    // ##########################################################################
    // Buffer state.
    // ##########################################################################

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (fill) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill) begin
            tag_q  <= fetch_addr_i;
            word_q <= mem_ch.rdata;     // Hit seen one cycle later.
        end
    end

endmodule

/* src/timer_regs.sv */
// Free-running cycle counter with byte-wise load through a request channel.
`timescale 1ns/1ns

module timer_regs (
    input  logic          clk_i,
    input  logic          rst_n_i,

    mem_req_if.responder  bus
);
    import mem_pkg::*;

    word_t count_q;
    word_t count_d;

    assign bus.ready = 1'b1;        // Never stalls.
    assign bus.rdata = count_q;

    // A write replaces the increment for that cycle.
    always_comb begin
        count_d = count_q + 32'd1;
        if (bus.valid && (bus.wstrb != '0)) begin
            for (int i = 0; i < 4; i++) begin
                count_d[8*i +: 8] = bus.wstrb[i] ? bus.wdata[8*i +: 8]
                                                 : count_q[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

endmodule

/* src/mem_arbiter.sv */
// Arbiter granting data or fetch requests onto the external memory bus.
`timescale 1ns/1ns

module mem_arbiter (
    input  logic            clk_i,
    input  logic            rst_n_i,

    mem_req_if.responder    data_ch,
    mem_req_if.responder    fetch_ch,

    output logic            mem_valid_o,
    input  logic            mem_ready_i,
    output mem_pkg::strb_t  mem_wstrb_o,
    output mem_pkg::waddr_t mem_addr_o,
    output mem_pkg::word_t  mem_wdata_o,
    input  mem_pkg::word_t  mem_rdata_i
);
    import mem_pkg::*;

    grant_e state_q;
    grant_e state_d;
    logic   done;

    assign done = mem_valid_o && mem_ready_i;

    // ##########################################################################
    // Grant FSM.
    // ##########################################################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (data_ch.valid) begin
                    state_d = DATA;         // Data first.
                end else if (fetch_ch.valid) begin
                    state_d = FETCH;
                end
            end
            DATA, FETCH: begin
                if (done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ##########################################################################
    // Payload and response routing.
    // ##########################################################################

    always_comb begin
        mem_valid_o = 1'b0;
        mem_wstrb_o = '0;
        mem_addr_o  = '0;
        mem_wdata_o = '0;
        if (state_q == DATA) begin
            mem_valid_o = data_ch.valid;
            mem_wstrb_o = data_ch.wstrb;
            mem_addr_o  = data_ch.addr;
            mem_wdata_o = data_ch.wdata;
        end else if (state_q == FETCH) begin
            mem_valid_o = fetch_ch.valid;
            mem_wstrb_o = fetch_ch.wstrb;
            mem_addr_o  = fetch_ch.addr;
            mem_wdata_o = fetch_ch.wdata;
        end
    end

    assign data_ch.ready  = (state_q == DATA) && mem_ready_i;
    assign data_ch.rdata  = (state_q == DATA) ? mem_rdata_i : '0;
    assign fetch_ch.ready = (state_q == FETCH) && mem_ready_i;
    assign fetch_ch.rdata = (state_q == FETCH) ? mem_rdata_i : '0;

endmodule

/* src/mem_subsystem.sv */
// Memory subsystem top level with core data, fetch and external memory ports.
`timescale 1ns/1ns

module mem_subsystem (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // Core data bus.
    input  logic            data_sel_i,
    input  mem_pkg::addr_t  data_addr_i,
    input  mem_pkg::word_t  data_wdata_i,
    input  mem_pkg::strb_t  data_mask_i,
    output mem_pkg::word_t  data_rdata_o,
    output logic            data_stall_o,

    // Instruction fetch.
    input  mem_pkg::waddr_t fetch_addr_i,
    output mem_pkg::word_t  fetch_word_o,
    output logic            fetch_wait_o,

    // External memory.
    output logic            mem_valid_o,
    input  logic            mem_ready_i,
    output mem_pkg::strb_t  mem_wstrb_o,
    output mem_pkg::waddr_t mem_addr_o,
    output mem_pkg::word_t  mem_wdata_o,
    input  mem_pkg::word_t  mem_rdata_i
);

    mem_req_if data_ch ();
    mem_req_if fetch_ch ();
    mem_req_if timer_ch ();

    bus_decoder i_bus_decoder (
        .data_sel_i   (data_sel_i),
        .data_addr_i  (data_addr_i),
        .data_wdata_i (data_wdata_i),
        .data_mask_i  (data_mask_i),
        .data_rdata_o (data_rdata_o),
        .data_stall_o (data_stall_o),
        .mem_ch       (data_ch.requester),
        .timer_ch     (timer_ch.requester)
    );

    fetch_buffer i_fetch_buffer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_addr_i (fetch_addr_i),
        .fetch_word_o (fetch_word_o),
        .fetch_wait_o (fetch_wait_o),
        .mem_ch       (fetch_ch.requester)
    );

    timer_regs i_timer_regs (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (timer_ch.responder)
    );

    mem_arbiter i_mem_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .data_ch     (data_ch.responder),
        .fetch_ch    (fetch_ch.responder),
        .mem_valid_o (mem_valid_o),
        .mem_ready_i (mem_ready_i),
        .mem_wstrb_o (mem_wstrb_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

/* tests/mem_model.sv */
// Behavioral external memory with random ready delay and a transfer log.
`timescale 1ns/1ns

module mem_model (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            valid_i,
    output logic            ready_o,
    input  mem_pkg::strb_t  wstrb_i,
    input  mem_pkg::waddr_t addr_i,
    input  mem_pkg::word_t  wdata_i,
    output mem_pkg::word_t  rdata_o
);
    import mem_pkg::*;

    word_t  mem [0:131071];
    waddr_t log_addr [0:255];   // Word address of every completed transfer.
    int     xfer_count;
    int     wait_q;             // Cycles left before ready.

    // Fill pattern built from the whole word address.
    initial begin
        for (int a = 0; a < 131072; a++) begin
            mem[a] = {~a[14:0], a[16:0]};
        end
    end

    assign ready_o = valid_i && (wait_q == 0);
    assign rdata_o = mem[addr_i];

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_q     <= 0;
            xfer_count <= 0;
        end else if (valid_i && ready_o) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb_i[i]) begin
                    mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
            log_addr[xfer_count[7:0]] <= addr_i;
            xfer_count <= xfer_count + 1;
            wait_q     <= $urandom_range(3, 0);  // Delay for the next request.
        end else if (valid_i && (wait_q != 0)) begin
            wait_q <= wait_q - 1;
        end
    end

endmodule

/* tests/tb_mem_subsystem.sv */
// Testbench with clock, reset, stimulus, reference function, compare tasks and timeout.
`timescale 1ns/1ns

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int    HALF_PERIOD  = 20;
    localparam int    RESET_CYCLES = 8;
    localparam int    TEST_CYCLES  = RESET_CYCLES + 40 * 10;   // 40 accesses of at most 10 cycles.
    localparam int    TIMEOUT      = 2 * TEST_CYCLES;
    localparam addr_t MEM_BASE     = 32'h4000_0000;
    localparam addr_t TIMER_ADDR   = 32'h1000_0000;
    localparam addr_t UNMAPPED     = 32'h0000_0410;            // Aliases memory word 0x104.

    logic   clk_i = 1'b0;
    logic   rst_n_i, data_sel_i, data_stall_o, fetch_wait_o, mem_valid_o, mem_ready_i;
    addr_t  data_addr_i;
    word_t  data_wdata_i, data_rdata_o, fetch_word_o, mem_wdata_o, mem_rdata_i;
    strb_t  data_mask_i, mem_wstrb_o;
    waddr_t fetch_addr_i, mem_addr_o;

    word_t  shadow [0:131071];
    int     cycle = 0;
    int     last_cycle;     // Cycle count in the completing cycle of a data access.

    mem_subsystem i_mem_subsystem (.*);

    mem_model i_mem_model (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (mem_valid_o),
        .ready_o (mem_ready_i),
        .wstrb_i (mem_wstrb_o),
        .addr_i  (mem_addr_o),
        .wdata_i (mem_wdata_o),
        .rdata_o (mem_rdata_i)
    );

    always #HALF_PERIOD clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            fail_run($sformatf("Timeout, the DUT did not finish within %0d cycles.", TIMEOUT));
        end
    end

    // ##########################################################################
    // Reference model and compare tasks.
    // ##########################################################################

    function automatic addr_t byte_addr(waddr_t w);
        return MEM_BASE | {13'd0, w, 2'b00};
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t wd, strb_t m);
        word_t r;
        r = old;
        for (int i = 0; i < 4; i++) begin
            if (m[i]) begin
                r[8*i +: 8] = wd[8*i +: 8];
            end
        end
        return r;
    endfunction

    // Timer reads give the loaded value plus the cycles since the load.
    function automatic word_t expected_read(addr_t a, word_t timer_base, int elapsed);
        if (a[MEM_SEL_BIT]) begin
            return shadow[a[WADDR_MSB:WADDR_LSB]];
        end else if (a[TIMER_SEL_BIT]) begin
            return timer_base + elapsed;
        end
        return '0;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
        end
    endtask

    // ##########################################################################
    // Bus tasks that start and end on a falling edge.
    // ##########################################################################

    task automatic data_access(input addr_t a, input word_t wd, input strb_t m,
                               output word_t rd, output logic stalled);
        data_sel_i   = 1'b1;
        data_addr_i  = a;
        data_wdata_i = wd;
        data_mask_i  = m;
        #(HALF_PERIOD / 2);
        stalled = data_stall_o;     // Stall as seen in the first cycle.
        while (data_stall_o) begin
            @(negedge clk_i);
            #(HALF_PERIOD / 2);
        end
        rd         = data_rdata_o;
        last_cycle = cycle;
        @(negedge clk_i);
        data_sel_i  = 1'b0;
        data_mask_i = '0;
    endtask

    task automatic fetch_wait_done(output word_t w, output logic missed);
        #(HALF_PERIOD / 2);
        missed = fetch_wait_o;
        while (fetch_wait_o) begin
            @(negedge clk_i);
            #(HALF_PERIOD / 2);
        end
        w = fetch_word_o;
        @(negedge clk_i);
    endtask

    initial begin
        word_t  rd;
        word_t  fw;
        word_t  v;
        word_t  base;
        strb_t  m;
        waddr_t wa;
        logic   stalled;
        logic   missed;
        int     n0;
        int     c0;

        void'($urandom(32'h7faf));
        for (int a = 0; a < 131072; a++) begin
            shadow[a] = {~a[14:0], a[16:0]};
        end
        rst_n_i      = 1'b0;
        data_sel_i   = 1'b0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        data_mask_i  = '0;
        fetch_addr_i = 17'h1000;
        base         = '0;
        c0           = 0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        check_flag("reset_mem_valid", 1'b0, mem_valid_o);

        // First fetch after reset misses.
        rst_n_i = 1'b1;
        #(HALF_PERIOD / 2);
        check_flag("release_mem_valid", 1'b0, mem_valid_o);
        check_flag("first_fetch_wait", 1'b1, fetch_wait_o);
        @(negedge clk_i);
        fetch_wait_done(fw, missed);
        check_word("first_fetch_word", expected_read(byte_addr(17'h1000), '0, 0), fw);

        // Masked memory writes, then read back every word.
        for (int i = 0; i < 16; i++) begin
            wa = 17'h100 + 17'($urandom_range(7, 0));
            v  = $urandom;
            m  = strb_t'($urandom_range(15, 1));
            data_access(byte_addr(wa), v, m, rd, stalled);
            check_flag("mem_write_stall", 1'b1, stalled);
            shadow[wa] = merge_bytes(shadow[wa], v, m);
        end
        for (int i = 0; i < 8; i++) begin
            wa = 17'h100 + 17'(i);
            data_access(byte_addr(wa), '0, '0, rd, stalled);
            check_word("mem_read", expected_read(byte_addr(wa), '0, 0), rd);
        end

        // Timer load, then read after a random gap.
        for (int i = 0; i < 3; i++) begin
            v = $urandom;
            m = (i == 0) ? 4'hf : strb_t'($urandom_range(14, 1));
            data_access(TIMER_ADDR, v, m, rd, stalled);
            check_flag("timer_write_stall", 1'b0, stalled);
            if (i > 0) begin
                check_word("timer_old", expected_read(TIMER_ADDR, base, last_cycle - c0 - 1), rd);
            end
            base = merge_bytes(expected_read(TIMER_ADDR, base, last_cycle - c0 - 1), v, m);
            c0   = last_cycle;
            repeat ($urandom_range(5, 0)) @(negedge clk_i);
            data_access(TIMER_ADDR, '0, '0, rd, stalled);
            check_word("timer_read", expected_read(TIMER_ADDR, base, last_cycle - c0 - 1), rd);
        end

        // Unmapped accesses.
        n0 = i_mem_model.xfer_count;
        data_access(UNMAPPED, 32'hdead_beef, 4'hf, rd, stalled);
        check_flag("unmapped_stall", 1'b0, stalled);
        check_word("unmapped_read", expected_read(UNMAPPED, '0, 0), rd);
        if (i_mem_model.xfer_count != n0) begin
            fail_run("An unmapped access reached external memory.");
        end
        data_access(byte_addr(17'h104), '0, '0, rd, stalled);
        check_word("unmapped_alias", expected_read(byte_addr(17'h104), '0, 0), rd);

        // Fetch miss, then a hit on the same word.
        n0           = i_mem_model.xfer_count;
        fetch_addr_i = 17'h1001;
        fetch_wait_done(fw, missed);
        check_flag("fetch_miss", 1'b1, missed);
        check_word("fetch_miss_word", expected_read(byte_addr(17'h1001), '0, 0), fw);
        fetch_wait_done(fw, missed);
        check_flag("fetch_hit", 1'b0, missed);
        check_word("fetch_hit_word", expected_read(byte_addr(17'h1001), '0, 0), fw);
        repeat (3) @(negedge clk_i);
        if (i_mem_model.xfer_count != n0 + 1) begin
            fail_run("The fetch hit started a memory transfer.");
        end

        // Data access and fetch miss in the same cycle.
        n0           = i_mem_model.xfer_count;
        fetch_addr_i = 17'h1002;
        fork
            data_access(byte_addr(17'h105), '0, '0, rd, stalled);
            fetch_wait_done(fw, missed);
        join
        check_word("both_data", expected_read(byte_addr(17'h105), '0, 0), rd);
        check_word("both_fetch", expected_read(byte_addr(17'h1002), '0, 0), fw);
        if (i_mem_model.xfer_count != n0 + 2) begin
            fail_run("Expected two memory transfers for the data access and the fetch.");
        end
        if (i_mem_model.log_addr[n0] != 17'h105 || i_mem_model.log_addr[n0 + 1] != 17'h1002) begin
            fail_run("The fetch was granted before the data access.");
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

/* build.f */
src/mem_pkg.sv
src/mem_req_if.sv
src/bus_decoder.sv
src/fetch_buffer.sv
src/timer_regs.sv
src/mem_arbiter.sv
src/mem_subsystem.sv
tests/mem_model.sv
tests/tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - src/mem_pkg.sv
  - src/mem_req_if.sv
  - src/bus_decoder.sv
  - src/fetch_buffer.sv
  - src/timer_regs.sv
  - src/mem_arbiter.sv
  - src/mem_subsystem.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/tb_mem_subsystem.sv
